// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+src
+incdir+tests
src/fetch_pkg.sv
src/imem_if.sv
src/ifu.sv
src/imem_wb_bridge.sv
src/trap_regs.sv
src/jump_predecode.sv
src/fetch_top.sv
tests/tb_imem_model.sv
tests/tb_fetch.sv

// File: src/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// width of an instruction fetch address.
`define IM_ADDR_LEN 32

// width of one instruction word.
`define IM_DATA_LEN 32

// first fetch address after reset.
`define RESET_PC `IM_ADDR_LEN'h0000_0000

`endif

// File: src/fetch_pkg.sv
package fetch_pkg;

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // J-type layout, offset bits are scattered.
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    // B-type layout.
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef union packed {
        logic [31:0] raw;
        j_fields_t   j_view;
        b_fields_t   b_view;
    } inst_word_u;

    // byte offsets on the configuration bus.
    typedef enum logic [3:0] {
        TRAP_VEC     = 4'h0,
        EPC          = 4'h4,
        IRQ_TRIGGER  = 4'h8,
        ERET_TRIGGER = 4'hC
    } trap_reg_e;

endpackage

// File: src/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top (
    input  logic                      clk,
    input  logic                      rstn,
    output logic                      iwb_cyc,
    output logic                      iwb_stb,
    output logic                      iwb_we,
    output logic [`IM_ADDR_LEN - 1:0] iwb_adr,
    input  logic [`IM_DATA_LEN - 1:0] iwb_dat_i,
    input  logic                      iwb_ack,
    input  logic                      cwb_cyc,
    input  logic                      cwb_stb,
    input  logic                      cwb_we,
    input  logic [`IM_ADDR_LEN - 1:0] cwb_adr,
    input  logic [`IM_DATA_LEN - 1:0] cwb_dat_i,
    output logic [`IM_DATA_LEN - 1:0] cwb_dat_o,
    output logic                      cwb_ack,
    input  logic                      stall,
    output logic [`IM_ADDR_LEN - 1:0] pc,
    output logic [`IM_DATA_LEN - 1:0] inst,
    output logic                      inst_valid
);

    logic                      irq_en;
    logic [`IM_ADDR_LEN - 1:0] irq_vec;
    logic                      eret_en;
    logic [`IM_ADDR_LEN - 1:0] ret_epc;
    logic                      pc_jump_en;
    logic [`IM_ADDR_LEN - 1:0] pc_jump;
    logic                      pc_alu_en;
    logic [`IM_ADDR_LEN - 1:0] pc_alu;

    imem_if imem_bus ();

    ifu u_ifu (
        .clk        (clk),
        .rstn       (rstn),
        .irq_en     (irq_en),
        .irq_vec    (irq_vec),
        .eret_en    (eret_en),
        .ret_epc    (ret_epc),
        .pc_jump_en (pc_jump_en),
        .pc_jump    (pc_jump),
        .pc_alu_en  (pc_alu_en),
        .pc_alu     (pc_alu),
        .imem       (imem_bus.ifu),
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid),
        .stall      (stall)
    );

    imem_wb_bridge u_bridge (
        .clk       (clk),
        .rstn      (rstn),
        .imem      (imem_bus.mem),
        .iwb_cyc   (iwb_cyc),
        .iwb_stb   (iwb_stb),
        .iwb_we    (iwb_we),
        .iwb_adr   (iwb_adr),
        .iwb_dat_i (iwb_dat_i),
        .iwb_ack   (iwb_ack)
    );

    trap_regs u_trap_regs (
        .clk       (clk),
        .rstn      (rstn),
        .cwb_cyc   (cwb_cyc),
        .cwb_stb   (cwb_stb),
        .cwb_we    (cwb_we),
        .cwb_adr   (cwb_adr),
        .cwb_dat_i (cwb_dat_i),
        .cwb_dat_o (cwb_dat_o),
        .cwb_ack   (cwb_ack),
        .pc        (pc),
        .irq_en    (irq_en),
        .irq_vec   (irq_vec),
        .eret_en   (eret_en),
        .ret_epc   (ret_epc)
    );

    jump_predecode u_predecode (
        .clk        (clk),
        .rstn       (rstn),
        .inst       (inst),
        .pc         (pc),
        .inst_valid (inst_valid),
        .pc_jump_en (pc_jump_en),
        .pc_jump    (pc_jump),
        .pc_alu_en  (pc_alu_en),
        .pc_alu     (pc_alu)
    );

endmodule

// File: src/ifu.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module ifu (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      irq_en,
    input  logic [`IM_ADDR_LEN - 1:0] irq_vec,
    input  logic                      eret_en,
    input  logic [`IM_ADDR_LEN - 1:0] ret_epc,
    input  logic                      pc_jump_en,
    input  logic [`IM_ADDR_LEN - 1:0] pc_jump,
    input  logic                      pc_alu_en,
    input  logic [`IM_ADDR_LEN - 1:0] pc_alu,
    imem_if.ifu                       imem,
    output logic [`IM_ADDR_LEN - 1:0] pc,
    output logic [`IM_DATA_LEN - 1:0] inst,
    output logic                      inst_valid,
    input  logic                      stall
);

    logic                      redirect;
    logic [`IM_ADDR_LEN - 1:0] redirect_pc;
    logic [`IM_ADDR_LEN - 1:0] fetch_pc_nxt;
    logic [`IM_ADDR_LEN - 1:0] fetch_pc;
    logic [`IM_ADDR_LEN - 1:0] dlv_pc;
    logic                      req_pending;
    logic                      hold_valid;
    logic [`IM_DATA_LEN - 1:0] hold_word;

    // exception return wins, the direct jump loses.
    assign redirect    = eret_en | irq_en | pc_alu_en | pc_jump_en;
    assign redirect_pc = eret_en   ? ret_epc :
                         irq_en    ? irq_vec :
                         pc_alu_en ? pc_alu  :
                                     pc_jump;

    assign fetch_pc_nxt = redirect ? redirect_pc : (fetch_pc + `IM_ADDR_LEN'h4);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_pc <= `RESET_PC;
        end else if (imem.req | redirect) begin
            fetch_pc <= fetch_pc_nxt;
        end
    end

    // pc of the word delivered next.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dlv_pc <= `RESET_PC;
        end else if (redirect) begin
            dlv_pc <= redirect_pc;
        end else if (inst_valid) begin
            dlv_pc <= fetch_pc;
        end
    end

    // a request is in flight or its word is waiting.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_pending <= 1'b0;
        end else if (imem.req) begin
            req_pending <= 1'b1;
        end else if (inst_valid | redirect) begin
            req_pending <= 1'b0;
        end
    end

    // keeps a word that came back while the consumer stalled.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_valid <= 1'b0;
        end else if (redirect) begin
            hold_valid <= 1'b0;
        end else if (req_pending & stall & ~imem.busy) begin
            hold_valid <= 1'b1;
        end else if (inst_valid) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (~imem.busy & ~hold_valid) begin
            hold_word <= imem.rdata;
        end
    end

    assign imem.addr = fetch_pc;
    assign imem.req  = ~imem.busy & ~redirect & (inst_valid | ~req_pending);

    // a stale word after a redirect finds req_pending low and is dropped.
    assign inst_valid = ((req_pending & ~imem.busy) | hold_valid) & ~stall & ~redirect;
    assign inst       = hold_valid  ? hold_word  :
                        ~imem.busy  ? imem.rdata :
                                      `IM_DATA_LEN'h0;
    assign pc         = dlv_pc;

    // the memory side goes busy right after each request.
    a_req_then_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        imem.req |=> (imem.busy && !imem.req)
    );

endmodule

// File: src/imem_if.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

interface imem_if;

    logic                      req;
    logic [`IM_ADDR_LEN - 1:0] addr;
    logic [`IM_DATA_LEN - 1:0] rdata;
    logic                      busy;

    // fetch side issues the request.
    modport ifu (
        output req,
        output addr,
        input  rdata,
        input  busy
    );

    // memory side answers it.
    modport mem (
        input  req,
        input  addr,
        output rdata,
        output busy
    );

endinterface

// File: src/imem_wb_bridge.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module imem_wb_bridge (
    input  logic                      clk,
    input  logic                      rstn,
    imem_if.mem                       imem,
    output logic                      iwb_cyc,
    output logic                      iwb_stb,
    output logic                      iwb_we,
    output logic [`IM_ADDR_LEN - 1:0] iwb_adr,
    input  logic [`IM_DATA_LEN - 1:0] iwb_dat_i,
    input  logic                      iwb_ack
);

    logic                      cyc_q;
    logic [`IM_ADDR_LEN - 1:0] adr_q;
    logic [`IM_DATA_LEN - 1:0] rdata_q;

    // one classic read per request stays open until the slave acks.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cyc_q <= 1'b0;
        end else if (imem.req) begin
            cyc_q <= 1'b1;
        end else if (cyc_q & iwb_ack) begin
            cyc_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (imem.req) begin
            adr_q <= imem.addr;
        end
    end

    // held until the next request.
    always_ff @(posedge clk) begin
        if (cyc_q & iwb_ack) begin
            rdata_q <= iwb_dat_i;
        end
    end

    assign iwb_cyc = cyc_q;
    assign iwb_stb = cyc_q;
    assign iwb_we  = 1'b0;
    assign iwb_adr = adr_q;

    assign imem.busy  = cyc_q;
    assign imem.rdata = rdata_q;

    // an unacked strobe keeps cyc and the address until the slave answers.
    a_stb_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (iwb_stb && !iwb_ack) |=> (iwb_stb && iwb_cyc && $stable(iwb_adr))
    );

endmodule

// File: src/jump_predecode.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module jump_predecode (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`IM_DATA_LEN - 1:0] inst,
    input  logic [`IM_ADDR_LEN - 1:0] pc,
    input  logic                      inst_valid,
    output logic                      pc_jump_en,
    output logic [`IM_ADDR_LEN - 1:0] pc_jump,
    output logic                      pc_alu_en,
    output logic [`IM_ADDR_LEN - 1:0] pc_alu
);

    fetch_pkg::inst_word_u     iw;
    logic [`IM_ADDR_LEN - 1:0] j_off;
    logic [`IM_ADDR_LEN - 1:0] b_off;
    logic                      is_jal;
    logic                      is_bwd_branch;

    assign iw = inst;

    assign j_off = {{(`IM_ADDR_LEN - 21){iw.j_view.imm20}}, iw.j_view.imm20,
                    iw.j_view.imm19_12, iw.j_view.imm11, iw.j_view.imm10_1, 1'b0};
    assign b_off = {{(`IM_ADDR_LEN - 13){iw.b_view.imm12}}, iw.b_view.imm12,
                    iw.b_view.imm11, iw.b_view.imm10_5, iw.b_view.imm4_1, 1'b0};

    assign is_jal = (iw.j_view.opcode == fetch_pkg::OPC_JAL);

    // static prediction, only loops going back are taken.
    assign is_bwd_branch = (iw.b_view.opcode == fetch_pkg::OPC_BRANCH) & iw.b_view.imm12;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_jump_en <= 1'b0;
            pc_alu_en  <= 1'b0;
        end else begin
            pc_jump_en <= inst_valid & is_jal;
            pc_alu_en  <= inst_valid & is_bwd_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            pc_jump <= pc + j_off;
            pc_alu  <= pc + b_off;
        end
    end

endmodule

// File: src/trap_regs.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module trap_regs (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cwb_cyc,
    input  logic                      cwb_stb,
    input  logic                      cwb_we,
    input  logic [`IM_ADDR_LEN - 1:0] cwb_adr,
    input  logic [`IM_DATA_LEN - 1:0] cwb_dat_i,
    output logic [`IM_DATA_LEN - 1:0] cwb_dat_o,
    output logic                      cwb_ack,
    input  logic [`IM_ADDR_LEN - 1:0] pc,
    output logic                      irq_en,
    output logic [`IM_ADDR_LEN - 1:0] irq_vec,
    output logic                      eret_en,
    output logic [`IM_ADDR_LEN - 1:0] ret_epc
);

    fetch_pkg::trap_reg_e      reg_sel;
    logic                      access;
    logic                      wr;
    logic                      ack_q;
    logic                      irq_q;
    logic                      eret_q;
    logic [`IM_ADDR_LEN - 1:0] trap_vec;
    logic [`IM_ADDR_LEN - 1:0] epc;
    logic [`IM_DATA_LEN - 1:0] dat_q;

    assign reg_sel = fetch_pkg::trap_reg_e'(cwb_adr[3:0]);

    // ack_q blocks a second access while the first is being acked.
    assign access = cwb_cyc & cwb_stb & ~ack_q;
    assign wr     = access & cwb_we;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_q  <= 1'b0;
            irq_q  <= 1'b0;
            eret_q <= 1'b0;
        end else begin
            ack_q  <= access;
            irq_q  <= wr & (reg_sel == fetch_pkg::IRQ_TRIGGER);
            eret_q <= wr & (reg_sel == fetch_pkg::ERET_TRIGGER);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            trap_vec <= `RESET_PC;
        end else if (wr & (reg_sel == fetch_pkg::TRAP_VEC)) begin
            trap_vec <= cwb_dat_i;
        end
    end

    // saves the pc shown while the interrupt pulse is out.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            epc <= `RESET_PC;
        end else if (irq_q) begin
            epc <= pc;
        end else if (wr & (reg_sel == fetch_pkg::EPC)) begin
            epc <= cwb_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                fetch_pkg::TRAP_VEC: dat_q <= trap_vec;
                fetch_pkg::EPC:      dat_q <= epc;
                default:             dat_q <= `IM_DATA_LEN'h0;
            endcase
        end
    end

    assign cwb_dat_o = dat_q;
    assign cwb_ack   = ack_q;
    assign irq_en    = irq_q;
    assign irq_vec   = trap_vec;
    assign eret_en   = eret_q;
    assign ret_epc   = epc;

endmodule

// File: tests/tb_program.svh
// every word is an ADDI x1 carrying its own word address, except three control words.
function automatic logic [`IM_DATA_LEN - 1:0] program_word(
    input logic [`IM_ADDR_LEN - 1:0] addr
);
    fetch_pkg::inst_word_u w;
    logic [20:0]           joff;
    logic [12:0]           boff;
    joff  = 21'h00100;
    boff  = (addr == 32'h180) ? 13'h1FE0 : 13'h0010;
    w.raw = {addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    if (addr == 32'h40) begin
        w.j_view.imm20    = joff[20];
        w.j_view.imm10_1  = joff[10:1];
        w.j_view.imm11    = joff[11];
        w.j_view.imm19_12 = joff[19:12];
        w.j_view.rd       = 5'd0;
        w.j_view.opcode   = fetch_pkg::OPC_JAL;
    end else if (addr == 32'h180 || addr == 32'h1A0) begin
        w.b_view.imm12   = boff[12];
        w.b_view.imm10_5 = boff[10:5];
        w.b_view.rs2     = 5'd2;
        w.b_view.rs1     = 5'd1;
        w.b_view.funct3  = 3'b001;
        w.b_view.imm4_1  = boff[4:1];
        w.b_view.imm11   = boff[11];
        w.b_view.opcode  = fetch_pkg::OPC_BRANCH;
    end
    return w.raw;
endfunction

// File: tests/tb_fetch.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_fetch;

    `include "tb_program.svh"

    localparam logic [31:0] VEC = 32'h190;

    logic                      clk;
    logic                      rstn;
    logic                      iwb_cyc;
    logic                      iwb_stb;
    logic                      iwb_we;
    logic [`IM_ADDR_LEN - 1:0] iwb_adr;
    logic [`IM_DATA_LEN - 1:0] iwb_dat_i;
    logic                      iwb_ack;
    logic                      cwb_cyc;
    logic                      cwb_stb;
    logic                      cwb_we;
    logic [`IM_ADDR_LEN - 1:0] cwb_adr;
    logic [`IM_DATA_LEN - 1:0] cwb_dat_i;
    logic [`IM_DATA_LEN - 1:0] cwb_dat_o;
    logic                      cwb_ack;
    logic                      stall = 1'b0;
    logic [`IM_ADDR_LEN - 1:0] pc;
    logic [`IM_DATA_LEN - 1:0] inst;
    logic                      inst_valid;

    logic        stall_mode = 1'b0;
    integer      stall_seed = 32'hba3029ad;
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    logic [31:0] last_pc;
    logic [31:0] redir_pc;
    logic [31:0] shown_pc;
    logic [31:0] saved_epc;
    logic [31:0] rd;
    int          errors = 0;
    int          timeouts = 0;
    int          redir_seq = 0;
    int          seen_seq;
    int          valid_cnt;
    int          jal_hits;
    int          bwd_hits;
    int          fwd_hits;

    fetch_top UUT (.*);

    tb_imem_model mem (
        .clk   (clk),
        .rstn  (rstn),
        .cyc   (iwb_cyc),
        .stb   (iwb_stb),
        .adr   (iwb_adr),
        .dat_o (iwb_dat_i),
        .ack   (iwb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        stall = stall_mode && (2'($random(stall_seed)) == 2'd0);
    end

    function automatic logic [31:0] rule_next(input logic [31:0] a);
        if (a == 32'h40) return 32'h140;
        if (a == 32'h180) return 32'h160;
        return a + 32'h4;
    endfunction

    // reference pc, follows the program rule and the trap redirects.
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_pc    <= `RESET_PC;
            last_pc   <= `RESET_PC;
            seen_seq  <= 0;
            valid_cnt <= 0;
            jal_hits  <= 0;
            bwd_hits  <= 0;
            fwd_hits  <= 0;
        end else if (redir_seq != seen_seq) begin
            seen_seq <= redir_seq;
            exp_pc   <= redir_pc;
        end else if (inst_valid) begin
            exp_pc    <= rule_next(exp_pc);
            last_pc   <= exp_pc;
            valid_cnt <= valid_cnt + 1;
            jal_hits  <= jal_hits + int'(exp_pc == 32'h40);
            bwd_hits  <= bwd_hits + int'(exp_pc == 32'h180);
            fwd_hits  <= fwd_hits + int'(exp_pc == 32'h1A0);
        end
    end

    assign exp_inst = program_word(exp_pc);

    a_pc_order: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid |-> pc == exp_pc)
        else begin
            errors++;
            $display("[FAIL] %0t: pc %h, expected %h", $time, $sampled(pc), $sampled(exp_pc));
        end

    a_inst_word: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid |-> inst == exp_inst)
        else begin
            errors++;
            $display("[FAIL] %0t: inst %h, expected %h", $time, $sampled(inst),
                     $sampled(exp_inst));
        end

    a_stall_quiet: assert property (@(posedge clk) disable iff (!rstn)
        stall |-> !inst_valid)
        else begin
            errors++;
            $display("[FAIL] %0t: inst_valid high during stall", $time);
        end

    a_read_only: assert property (@(posedge clk) disable iff (!rstn)
        iwb_cyc |-> !iwb_we)
        else begin
            errors++;
            $display("[FAIL] %0t: write cycle on the instruction bus", $time);
        end

    task automatic wait_valids(input int n);
        int start;
        int cycles;
        start  = valid_cnt;
        cycles = 0;
        while (valid_cnt < start + n && cycles < 2000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (valid_cnt < start + n) begin
            timeouts++;
            $display("timeout: the fetch unit stopped delivering instructions");
        end
    endtask

    task automatic cfg_access(input logic we, input logic [3:0] off,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles    = 0;
        cwb_cyc   = 1'b1;
        cwb_stb   = 1'b1;
        cwb_we    = we;
        cwb_adr   = {28'h0, off};
        cwb_dat_i = wdata;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!cwb_ack && cycles < 20);
        if (!cwb_ack) begin
            timeouts++;
            $display("timeout: the configuration port never acknowledged");
        end
        rdata   = cwb_dat_o;
        cwb_cyc = 1'b0;
        cwb_stb = 1'b0;
        cwb_we  = 1'b0;
    endtask

    // starts right after a plain instruction so no predecode pulse meets the trap pulse.
    task automatic trigger(input logic [3:0] off, input logic [31:0] target);
        logic [31:0] unused;
        wait_valids(1);
        while ((last_pc == 32'h40 || last_pc == 32'h180) && timeouts == 0) begin
            wait_valids(1);
        end
        cfg_access(1'b1, off, 32'h0, unused);
        shown_pc = exp_pc;
        redir_pc = target;
        redir_seq++;
    endtask

    initial begin
        rstn      = 1'b0;
        cwb_cyc   = 1'b0;
        cwb_stb   = 1'b0;
        cwb_we    = 1'b0;
        cwb_adr   = '0;
        cwb_dat_i = '0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        // sequential run and the JAL, then a few turns of the loop.
        while (bwd_hits < 3 && timeouts == 0) wait_valids(1);
        cfg_access(1'b1, fetch_pkg::TRAP_VEC, VEC, rd);
        trigger(fetch_pkg::IRQ_TRIGGER, VEC);
        saved_epc = shown_pc;
        cfg_access(1'b0, fetch_pkg::EPC, 32'h0, rd);
        assert (rd == saved_epc) else begin
            errors++;
            $display("[FAIL] %0t: EPC read %h, expected %h", $time, rd, saved_epc);
        end
        while (fwd_hits < 1 && timeouts == 0) wait_valids(1);
        stall_mode = 1'b1;
        wait_valids(40);
        trigger(fetch_pkg::ERET_TRIGGER, saved_epc);
        wait_valids(12);
        stall_mode = 1'b0;
        if (jal_hits == 0 || bwd_hits < 4 || fwd_hits == 0) begin
            errors++;
            $display("the run did not reach every jump and branch case");
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_imem_model.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_imem_model (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic [`IM_ADDR_LEN - 1:0] adr,
    output logic [`IM_DATA_LEN - 1:0] dat_o,
    output logic                      ack
);

    `include "tb_program.svh"

    integer     seed = 32'hba3029ad;
    logic       started;
    logic [1:0] wait_left;

    // 0 to 3 random wait states on top of one fixed cycle.
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack       <= 1'b0;
            started   <= 1'b0;
            wait_left <= 2'd0;
            dat_o     <= '0;
        end else if (ack) begin
            ack     <= 1'b0;
            started <= 1'b0;
        end else if (cyc && stb) begin
            if (!started) begin
                started   <= 1'b1;
                wait_left <= 2'($random(seed));
            end else if (wait_left == 2'd0) begin
                ack   <= 1'b1;
                dat_o <= program_word(adr);
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule
